/* hw/ialu.sv */
`default_nettype none

`include "rv_exec_defines.svh"

module ialu (
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire logic                      issue_vld,
    input  wire rv_exec_pkg::t_uop         issue_uop,
    input  wire rv_exec_pkg::t_tag         issue_tag,
    input  wire rv_exec_pkg::t_rv_reg_data src1,
    input  wire rv_exec_pkg::t_rv_reg_data src2,
    input  wire rv_exec_pkg::t_rv_reg_data pc,

    output logic                           alu_vld,
    output rv_exec_pkg::t_tag              alu_tag,
    output rv_exec_pkg::t_rv_reg_data      alu_result
);
    import rv_exec_pkg::*;

    logic signed [`XLEN-1:0] src1_signed_ex0;
    logic signed [`XLEN-1:0] src2_signed_ex0;
    logic [4:0]              shamt_ex0;
    logic                    resvld_ex0;
    t_rv_reg_data            result_ex0;

    assign src1_signed_ex0 = src1;
    assign src2_signed_ex0 = src2;

    // Only the low 5 bits of src2 shift
    assign shamt_ex0 = src2[4:0];

    // EX0 result
    always_comb begin
        result_ex0 = '0;
        resvld_ex0 = issue_vld;
        case (issue_uop)
            U_ADD:   result_ex0 = src1 + src2;
            U_SUB:   result_ex0 = src1 - src2;
            U_AND:   result_ex0 = src1 & src2;
            U_OR:    result_ex0 = src1 | src2;
            U_XOR:   result_ex0 = src1 ^ src2;
            U_SLL:   result_ex0 = src1 << shamt_ex0;
            U_SRL:   result_ex0 = src1 >> shamt_ex0;
            U_SRA:   result_ex0 = src1_signed_ex0 >>> shamt_ex0;
            U_SLT:   result_ex0 = t_rv_reg_data'(src1_signed_ex0 < src2_signed_ex0);
            U_SLTU:  result_ex0 = t_rv_reg_data'(src1 < src2);
            U_LUI:   result_ex0 = src2;
            U_AUIPC: result_ex0 = src2 + pc;
            default: begin
                // Multiplies and illegal codes
                resvld_ex0 = 1'b0;
            end
        endcase
    end

    // End of EX0
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_vld <= 1'b0;
        end else begin
            alu_vld <= resvld_ex0;
        end
    end

    always_ff @(posedge clk) begin
        if (resvld_ex0) begin
            alu_tag    <= issue_tag;
            alu_result <= result_ex0;
        end
    end

endmodule

`default_nettype wire

/* hw/imul.sv */
`default_nettype none

`include "rv_exec_defines.svh"

module imul (
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire logic                      issue_vld,
    input  wire rv_exec_pkg::t_uop         issue_uop,
    input  wire rv_exec_pkg::t_tag         issue_tag,
    input  wire rv_exec_pkg::t_rv_reg_data src1,
    input  wire rv_exec_pkg::t_rv_reg_data src2,

    output logic                           mul_vld,
    output rv_exec_pkg::t_tag              mul_tag,
    output rv_exec_pkg::t_rv_reg_data      mul_result
);
    import rv_exec_pkg::*;

    logic                      mul_sel_ex0;
    logic                      a_signed_ex0;
    logic                      b_signed_ex0;

    // Stage 1, extended operands
    logic                      s1_vld;
    logic                      s1_hi;
    t_tag                      s1_tag;
    logic signed [`XLEN:0]     s1_a;
    logic signed [`XLEN:0]     s1_b;

    // Stage 2, full product
    logic                      s2_vld;
    logic                      s2_hi;
    t_tag                      s2_tag;
    logic signed [2*`XLEN+1:0] s2_prod;

    assign mul_sel_ex0  = issue_vld && (issue_uop inside {U_MUL, U_MULH, U_MULHSU, U_MULHU});
    assign a_signed_ex0 = issue_uop inside {U_MULH, U_MULHSU};
    assign b_signed_ex0 = (issue_uop == U_MULH);

    // Valid chain
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
            mul_vld <= 1'b0;
        end else begin
            s1_vld  <= mul_sel_ex0;
            s2_vld  <= s1_vld;
            mul_vld <= s2_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_sel_ex0) begin
            s1_tag <= issue_tag;
            s1_hi  <= (issue_uop != U_MUL);
            s1_a   <= {a_signed_ex0 & src1[`XLEN-1], src1};
            s1_b   <= {b_signed_ex0 & src2[`XLEN-1], src2};
        end
    end

    // 33x33 signed covers all three signedness mixes
    always_ff @(posedge clk) begin
        if (s1_vld) begin
            s2_tag  <= s1_tag;
            s2_hi   <= s1_hi;
            s2_prod <= s1_a * s1_b;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_vld) begin
            mul_tag    <= s2_tag;
            mul_result <= s2_hi ? s2_prod[2*`XLEN-1:`XLEN] : s2_prod[`XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

/* hw/rv_exec.sv */
`default_nettype none

`include "rv_exec_defines.svh"

module rv_exec (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // Issue port
    input  wire logic                      issue_vld,
    input  wire rv_exec_pkg::t_uop         issue_uop,
    input  wire rv_exec_pkg::t_tag         issue_tag,
    input  wire rv_exec_pkg::t_rv_reg_data src1,
    input  wire rv_exec_pkg::t_rv_reg_data src2,
    input  wire rv_exec_pkg::t_rv_reg_data pc,

    // Writeback bus
    output logic                           wb_vld,
    output rv_exec_pkg::t_tag              wb_tag,
    output rv_exec_pkg::t_rv_reg_data      wb_data
);
    import rv_exec_pkg::*;

    logic         alu_vld;
    t_tag         alu_tag;
    t_rv_reg_data alu_result;

    logic         mul_vld;
    t_tag         mul_tag;
    t_rv_reg_data mul_result;

    // Both units see every issue and pick their own ops
    ialu i_ialu (
        .clk        (clk),
        .rst        (rst),
        .issue_vld  (issue_vld),
        .issue_uop  (issue_uop),
        .issue_tag  (issue_tag),
        .src1       (src1),
        .src2       (src2),
        .pc         (pc),
        .alu_vld    (alu_vld),
        .alu_tag    (alu_tag),
        .alu_result (alu_result)
    );

    imul i_imul (
        .clk        (clk),
        .rst        (rst),
        .issue_vld  (issue_vld),
        .issue_uop  (issue_uop),
        .issue_tag  (issue_tag),
        .src1       (src1),
        .src2       (src2),
        .mul_vld    (mul_vld),
        .mul_tag    (mul_tag),
        .mul_result (mul_result)
    );

    wb_arbiter i_wb_arbiter (
        .clk        (clk),
        .rst        (rst),
        .alu_vld    (alu_vld),
        .alu_tag    (alu_tag),
        .alu_result (alu_result),
        .mul_vld    (mul_vld),
        .mul_tag    (mul_tag),
        .mul_result (mul_result),
        .wb_vld     (wb_vld),
        .wb_tag     (wb_tag),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

/* hw/rv_exec_defines.svh */
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// Register and datapath width
`define XLEN 32

// Micro-op tag width
`define TAG_W 4

// Multiplier pipeline depth from issue to result
`define MUL_STAGES 3

// Entries in the ALU writeback queue
`define WB_Q_DEPTH 4

`endif

/* hw/rv_exec_pkg.sv */
`default_nettype none

`include "rv_exec_defines.svh"

package rv_exec_pkg;

    // Operand, PC and result values
    typedef logic [`XLEN-1:0] t_rv_reg_data;

    // Tag that follows a micro-op to its writeback
    typedef logic [`TAG_W-1:0] t_tag;

    // Execute micro-op codes, codes 5'h10 and up are illegal
    typedef enum logic [4:0] {
        U_ADD    = 5'h00,
        U_SUB    = 5'h01,
        U_AND    = 5'h02,
        U_OR     = 5'h03,
        U_XOR    = 5'h04,
        U_SLL    = 5'h05,
        U_SRL    = 5'h06,
        U_SRA    = 5'h07,
        U_SLT    = 5'h08,
        U_SLTU   = 5'h09,
        U_LUI    = 5'h0a,
        U_AUIPC  = 5'h0b,
        // Multiplier ops
        U_MUL    = 5'h0c,
        U_MULH   = 5'h0d,
        U_MULHSU = 5'h0e,
        U_MULHU  = 5'h0f
    } t_uop;

endpackage

`default_nettype wire

/* hw/wb_arbiter.sv */
`default_nettype none

`include "rv_exec_defines.svh"

module wb_arbiter (
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire logic                      alu_vld,
    input  wire rv_exec_pkg::t_tag         alu_tag,
    input  wire rv_exec_pkg::t_rv_reg_data alu_result,

    input  wire logic                      mul_vld,
    input  wire rv_exec_pkg::t_tag         mul_tag,
    input  wire rv_exec_pkg::t_rv_reg_data mul_result,

    output logic                           wb_vld,
    output rv_exec_pkg::t_tag              wb_tag,
    output rv_exec_pkg::t_rv_reg_data      wb_data
);
    import rv_exec_pkg::*;

    localparam int PTR_W = (`WB_Q_DEPTH > 1) ? $clog2(`WB_Q_DEPTH) : 1;
    localparam int CNT_W = $clog2(`WB_Q_DEPTH + 1);

    // ALU result queue
    t_tag             q_tag  [`WB_Q_DEPTH];
    t_rv_reg_data     q_data [`WB_Q_DEPTH];
    logic [PTR_W-1:0] q_rd_ptr;
    logic [PTR_W-1:0] q_wr_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_empty;
    logic             q_full;
    logic             q_push;
    logic             q_pop;

    logic             sel_vld;
    t_tag             sel_tag;
    t_rv_reg_data     sel_data;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`WB_Q_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign q_empty = (q_count == '0);
    assign q_full  = (q_count == CNT_W'(`WB_Q_DEPTH));

    // Multiplier first, then queue head, then a fresh ALU result
    always_comb begin
        sel_vld  = 1'b0;
        sel_tag  = alu_tag;
        sel_data = alu_result;
        q_push   = 1'b0;
        q_pop    = 1'b0;
        if (mul_vld) begin
            sel_vld  = 1'b1;
            sel_tag  = mul_tag;
            sel_data = mul_result;
            q_push   = alu_vld;
        end else if (!q_empty) begin
            sel_vld  = 1'b1;
            sel_tag  = q_tag[q_rd_ptr];
            sel_data = q_data[q_rd_ptr];
            q_pop    = 1'b1;
            // Keep ALU order behind older entries
            q_push   = alu_vld;
        end else if (alu_vld) begin
            sel_vld  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_rd_ptr <= '0;
            q_wr_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (q_push) begin
                q_wr_ptr <= ptr_inc(q_wr_ptr);
            end
            if (q_pop) begin
                q_rd_ptr <= ptr_inc(q_rd_ptr);
            end
            q_count <= q_count + CNT_W'(q_push) - CNT_W'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_tag[q_wr_ptr]  <= alu_tag;
            q_data[q_wr_ptr] <= alu_result;
        end
    end

    // Writeback bus
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_vld <= 1'b0;
        end else begin
            wb_vld <= sel_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_vld) begin
            wb_tag  <= sel_tag;
            wb_data <= sel_data;
        end
    end

    // Issue rate bounds the queue
    a_q_overflow: assert property (@(posedge clk) disable iff (rst)
        (q_push && !q_pop) |-> !q_full)
        else $error("wb_arbiter ALU queue overflow");

    // Tags are unique while outstanding
    a_tag_clash: assert property (@(posedge clk) disable iff (rst)
        (alu_vld && mul_vld) |-> (alu_tag != mul_tag))
        else $error("ALU and multiplier present the same tag");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the rv_exec testbench with Verilator, run it, and check the log

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_rv_exec -o sim_rv_exec \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_rv_exec > "$LOG" 2>&1
cat "$LOG"

grep -q "TEST RESULT: FAIL" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* src.f */
+incdir+hw
hw/rv_exec_pkg.sv
hw/ialu.sv
hw/imul.sv
hw/wb_arbiter.sv
hw/rv_exec.sv
test/tb_rv_exec.sv

/* test/exec_patterns.txt */
# test uop src1 src2 pc expected illegal, all columns in hex
# illegal 1 marks an unused uop code that must produce no writeback
1 00 7fffffff 00000001 00000000 80000000 0
1 00 12345678 edcba988 00000000 00000000 0
1 01 00000000 00000001 00000000 ffffffff 0
1 02 f0f0a5a5 0ff05a5a 00000000 00f00000 0
1 03 f0f0a5a5 0ff05a5a 00000000 fff0ffff 0
1 04 f0f0a5a5 0ff05a5a 00000000 ff00ffff 0
2 05 00000001 0000001f 00000000 80000000 0
2 05 00000001 00000021 00000000 00000002 0
2 06 f0000000 00000104 00000000 0f000000 0
2 07 80000000 0000001f 00000000 ffffffff 0
2 07 70000000 00000004 00000000 07000000 0
2 08 ffffffff 00000001 00000000 00000001 0
2 09 ffffffff 00000001 00000000 00000000 0
2 08 00000001 ffffffff 00000000 00000000 0
2 09 00000001 ffffffff 00000000 00000001 0
3 0a abcdef01 fffff000 00000000 fffff000 0
3 0b 00000000 00001000 80000000 80001000 0
3 0b 00000000 80000000 80000004 00000004 0
4 0c 00000007 00000006 00000000 0000002a 0
4 0c ffffffff ffffffff 00000000 00000001 0
4 0d ffffffff ffffffff 00000000 00000000 0
4 0f ffffffff ffffffff 00000000 fffffffe 0
4 0e ffffffff ffffffff 00000000 ffffffff 0
4 0d 7fffffff 80000000 00000000 c0000000 0
4 0e 00000002 80000000 00000000 00000001 0
5 0c 00000003 00000005 00000000 0000000f 0
5 0d 7fffffff 7fffffff 00000000 3fffffff 0
5 00 00000010 00000020 00000000 00000030 0
5 01 00000100 00000001 00000000 000000ff 0
5 0f 00010000 00010000 00000000 00000001 0
5 02 ffff0000 0f0f0f0f 00000000 0f0f0000 0
5 05 00000003 00000002 00000000 0000000c 0
5 0d 00000002 80000000 00000000 ffffffff 0
5 0e fffffffe 00000003 00000000 ffffffff 0
5 0b 00000000 00000004 00000100 00000104 0
5 07 c0000000 00000002 00000000 f0000000 0
5 0c fffffffe 00000003 00000000 fffffffa 0
6 00 00000001 00000001 00000000 00000002 0
6 10 11111111 22222222 00000000 deadbeef 1
6 0c 00000004 00000004 00000000 00000010 0
6 1f 33333333 44444444 00000000 deadbeef 1
6 01 00000009 00000003 00000000 00000006 0
6 15 55555555 66666666 00000000 deadbeef 1

/* test/tb_rv_exec.sv */
`default_nettype none

`include "rv_exec_defines.svh"

module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_TAGS = 1 << `TAG_W;
    // Group issued back to back so results collide on the bus
    localparam int BURST_TEST = 5;

    logic         clk;
    logic         rst;
    logic         issue_vld;
    t_uop         issue_uop;
    t_tag         issue_tag;
    t_rv_reg_data src1;
    t_rv_reg_data src2;
    t_rv_reg_data pc;
    logic         wb_vld;
    t_tag         wb_tag;
    t_rv_reg_data wb_data;

    // Pattern table
    int           pat_test[$];
    logic [4:0]   pat_uop[$];
    t_rv_reg_data pat_src1[$];
    t_rv_reg_data pat_src2[$];
    t_rv_reg_data pat_pc[$];
    t_rv_reg_data pat_exp[$];
    logic         pat_illegal[$];

    // A tag is in flight while its issue count runs ahead of its retire count
    int unsigned  issued_cnt [NUM_TAGS] = '{default: 0};
    int unsigned  retired_cnt [NUM_TAGS] = '{default: 0};
    t_rv_reg_data expected [NUM_TAGS];

    int           seed;
    int           drv_errors;
    int           mon_errors = 0;
    int           tests_passed;
    int           tests_failed;
    t_tag         next_tag;

    rv_exec i_dut (
        .clk       (clk),
        .rst       (rst),
        .issue_vld (issue_vld),
        .issue_uop (issue_uop),
        .issue_tag (issue_tag),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .wb_vld    (wb_vld),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic in_flight(input t_tag tag);
        return issued_cnt[tag] != retired_cnt[tag];
    endfunction

    function automatic logic any_in_flight();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (in_flight(t_tag'(t))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Rising edge sees the bus values of the cycle that just ended
    always @(posedge clk) begin
        if (!rst && wb_vld === 1'b1) begin
            assert (in_flight(wb_tag)) else begin
                $display("Writeback with tag %0h that has no micro-op in flight", wb_tag);
                mon_errors++;
            end
            if (in_flight(wb_tag)) begin
                assert (wb_data == expected[wb_tag]) else begin
                    $display("mismatch wb_data tag %0h: got 0x%08h expected 0x%08h",
                             wb_tag, wb_data, expected[wb_tag]);
                    mon_errors++;
                end
                retired_cnt[wb_tag]++;
            end
        end
    end

    task automatic load_patterns();
        int           fd;
        int           n;
        string        line;
        int           t;
        logic [4:0]   u;
        t_rv_reg_data a;
        t_rv_reg_data b;
        t_rv_reg_data p;
        t_rv_reg_data e;
        logic         il;
        fd = $fopen("test/exec_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open the pattern file test/exec_patterns.txt");
            drv_errors++;
        end
        if (fd != 0) begin
            // Comment and blank lines do not scan to seven fields
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", t, u, a, b, p, e, il);
                if (n == 7) begin
                    pat_test.push_back(t);
                    pat_uop.push_back(u);
                    pat_src1.push_back(a);
                    pat_src2.push_back(b);
                    pat_pc.push_back(p);
                    pat_exp.push_back(e);
                    pat_illegal.push_back(il);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_op(input int idx);
        int waited;
        waited = 0;
        // Reuse a tag only after its earlier writeback
        while (in_flight(next_tag) && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (!in_flight(next_tag)) else begin
            $display("Timed out waiting for tag %0h to be written back", next_tag);
            drv_errors++;
        end
        issue_vld = 1'b1;
        issue_uop = t_uop'(pat_uop[idx]);
        issue_tag = next_tag;
        src1      = pat_src1[idx];
        src2      = pat_src2[idx];
        pc        = pat_pc[idx];
        if (!pat_illegal[idx]) begin
            expected[next_tag] = pat_exp[idx];
            issued_cnt[next_tag]++;
        end
        next_tag++;
        @(negedge clk);
        issue_vld = 1'b0;
    endtask

    task automatic drain(input int test);
        int waited;
        waited = 0;
        while (any_in_flight() && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (!any_in_flight()) else begin
            $display("Test %0d timed out with writebacks still missing", test);
            drv_errors++;
        end
        // Room for a stray writeback from an illegal code
        repeat (`MUL_STAGES + 2) @(negedge clk);
    endtask

    initial begin
        int idx;
        int cur_test;
        int errors_before;
        int gap;
        rst          = 1'b1;
        issue_vld    = 1'b0;
        issue_uop    = U_ADD;
        issue_tag    = '0;
        src1         = '0;
        src2         = '0;
        pc           = '0;
        seed         = 32'hbfb2_32fc;
        drv_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        next_tag     = '0;
        load_patterns();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        idx = 0;
        while (idx < pat_test.size()) begin
            cur_test      = pat_test[idx];
            errors_before = drv_errors + mon_errors;
            while (idx < pat_test.size() && pat_test[idx] == cur_test) begin
                issue_op(idx);
                if (cur_test != BURST_TEST) begin
                    gap = int'($unsigned($random(seed)) % 32'd3);
                    repeat (gap) @(negedge clk);
                end
                idx++;
            end
            drain(cur_test);
            if (drv_errors + mon_errors == errors_before) begin
                $display("Test %0d passed", cur_test);
                tests_passed++;
            end else begin
                $display("Test %0d failed with %0d errors", cur_test,
                         drv_errors + mon_errors - errors_before);
                tests_failed++;
            end
        end

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (drv_errors + mon_errors == 0 && tests_failed == 0 && pat_test.size() > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
